// File: mem_stage.f
source/mem_pkg.sv
source/mem_amo_alu.sv
source/mem_lanes.sv
source/mem_access_ctrl.sv
source/mem_request.sv
source/mem_stage.sv
tb/tb_clock.sv
tb/tb_mem_stage.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_mem_stage
RTL_TOP   ?= mem_stage
FILELIST  ?= mem_stage.f
BUILD     ?= obj_dir
SIM_BIN   ?= sim

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD) -o $(SIM_BIN)
	./$(BUILD)/$(SIM_BIN)

clean:
	rm -rf $(BUILD)

// File: tb/tb_mem_stage.sv
// Testbench for the memory stage with a wait-state memory model and a shadow memory.
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

    logic        clk;
    logic        rst;
    logic        d_valid;
    logic        d_ready;
    logic [31:0] d_insn;
    logic [31:0] d_addr;
    logic [31:0] d_wdata;
    logic        bus_re;
    logic [3:0]  bus_we;
    logic [29:0] bus_addr;
    logic [31:0] bus_wdata;
    logic        bus_ready;
    logic [31:0] bus_rdata;
    logic        q_valid;
    logic [31:0] q_rd_val;
    logic        q_trap;
    logic [3:0]  q_cause;

    // Memory contents and the expected copy.
    logic [31:0] mem    [0:63];
    logic [31:0] shadow [0:63];
    int          wait_left = 0;

    // Expected results, oldest at head.
    logic [31:0] exp_val   [0:1023];
    logic        exp_trap  [0:1023];
    logic [3:0]  exp_cause [0:1023];
    logic [3:0]  exp_we    [0:1023];
    logic        exp_re    [0:1023];
    logic [29:0] exp_addr  [0:1023];
    int          exp_id    [0:1023];
    int          head   = 0;
    int          tail   = 0;
    int          issued = 0;

    logic [31:0] cur_val;
    logic        cur_trap;
    logic [3:0]  cur_cause;
    logic [3:0]  cur_we;
    logic        cur_re;
    logic [29:0] cur_addr;
    int          cur_id;

    int f5_list [0:8] = '{0, 1, 4, 8, 12, 16, 20, 24, 28};

    tb_clock #(.period_ns(20)) u_clock (.clk(clk));

    mem_stage #(.has_amo(1'b1)) dut (
        .clk       (clk),
        .rst       (rst),
        .d_valid   (d_valid),
        .d_ready   (d_ready),
        .d_insn    (d_insn),
        .d_addr    (d_addr),
        .d_wdata   (d_wdata),
        .bus_re    (bus_re),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ready (bus_ready),
        .bus_rdata (bus_rdata),
        .q_valid   (q_valid),
        .q_rd_val  (q_rd_val),
        .q_trap    (q_trap),
        .q_cause   (q_cause)
    );

    assign cur_val   = exp_val[head];
    assign cur_trap  = exp_trap[head];
    assign cur_cause = exp_cause[head];
    assign cur_we    = exp_we[head];
    assign cur_re    = exp_re[head];
    assign cur_addr  = exp_addr[head];
    assign cur_id    = exp_id[head];

    function automatic string test_name(input int id);
        case (id)
            1:       return "loads";
            2:       return "stores";
            3:       return "misalign";
            4:       return "atomics";
            5:       return "illegal";
            default: return "random";
        endcase
    endfunction

    function automatic logic [31:0] enc_load(input logic [2:0] f3);
        return {12'h000, 5'd1, f3, 5'd2, 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_store(input logic [2:0] f3);
        return {7'h00, 5'd3, 5'd1, f3, 5'd0, 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_amo(input logic [4:0] f5, input logic [2:0] f3);
        return {f5, 2'b00, 5'd3, 5'd1, f3, 5'd2, 7'b0101111};
    endfunction

    // Value an atomic leaves in memory.
    function automatic logic [31:0] amo_result(input logic [4:0] f5, input logic [31:0] old,
                                               input logic [31:0] op);
        case (f5)
            5'd0:    return old + op;
            5'd1:    return op;
            5'd4:    return old ^ op;
            5'd8:    return old | op;
            5'd12:   return old & op;
            5'd16:   return ($signed(old) < $signed(op)) ? old : op;
            5'd20:   return ($signed(old) > $signed(op)) ? old : op;
            5'd24:   return (old < op) ? old : op;
            default: return (old > op) ? old : op;
        endcase
    endfunction

    // Expected outcome of one instruction, applied to the shadow memory in issue order.
    task automatic predict(input logic [31:0] insn, input logic [31:0] addr,
                           input logic [31:0] wdata, input int id);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  f5;
        logic [5:0]  w;
        logic [1:0]  off;
        logic [31:0] old;
        logic [31:0] data;
        logic [31:0] val;
        logic [3:0]  we;
        logic        re;
        logic        trap;
        logic [3:0]  cause;
        int          sh;
        opc   = insn[6:0];
        f3    = insn[14:12];
        f5    = insn[31:27];
        w     = addr[7:2];
        off   = addr[1:0];
        old   = shadow[w];
        data  = 32'h0;
        val   = 32'h0;
        we    = 4'h0;
        re    = 1'b0;
        trap  = 1'b0;
        cause = 4'd0;
        sh    = 8 * int'(off);
        if (opc == 7'b0000011 && f3[1:0] != 2'b11) begin
            if ((f3[1:0] == 2'b01 && off[0]) || (f3[1:0] == 2'b10 && off != 2'b00)) begin
                trap  = 1'b1;
                cause = 4'd4;
            end else begin
                re  = 1'b1;
                val = old >> sh;
                if (f3[1:0] == 2'b00) begin
                    val = f3[2] ? {24'h0, val[7:0]} : {{24{val[7]}}, val[7:0]};
                end else if (f3[1:0] == 2'b01) begin
                    val = f3[2] ? {16'h0, val[15:0]} : {{16{val[15]}}, val[15:0]};
                end else begin
                    val = old;
                end
            end
        end else if (opc == 7'b0100011 && f3[1:0] != 2'b11) begin
            if ((f3[1:0] == 2'b01 && off[0]) || (f3[1:0] == 2'b10 && off != 2'b00)) begin
                trap  = 1'b1;
                cause = 4'd6;
            end else if (f3[1:0] == 2'b00) begin
                data = {4{wdata[7:0]}};
                we   = 4'b0001 << off;
            end else if (f3[1:0] == 2'b01) begin
                data = {2{wdata[15:0]}};
                we   = off[1] ? 4'b1100 : 4'b0011;
            end else begin
                data = wdata;
                we   = 4'b1111;
            end
        end else if (opc == 7'b0101111 && f3 == 3'b010 &&
                     (f5[1:0] == 2'b00 || f5 == 5'b00001)) begin
            if (off != 2'b00) begin
                trap  = 1'b1;
                cause = 4'd6;
            end else begin
                re   = 1'b1;
                val  = old;
                data = amo_result(f5, old, wdata);
                we   = 4'b1111;
            end
        end else begin
            trap  = 1'b1;
            cause = 4'd2;
        end
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                shadow[w][8*i +: 8] = data[8*i +: 8];
            end
        end
        exp_val[tail]   = val;
        exp_trap[tail]  = trap;
        exp_cause[tail] = cause;
        exp_we[tail]    = we;
        exp_re[tail]    = re;
        exp_addr[tail]  = addr[31:2];
        exp_id[tail]    = id;
        tail = tail + 1;
    endtask

    // Hand one instruction to the DUT once it is ready.
    task automatic issue(input logic [31:0] insn, input logic [31:0] addr,
                         input logic [31:0] wdata, input int id);
        @(posedge clk);
        #2;
        while (!d_ready) begin
            @(posedge clk);
            #2;
        end
        predict(insn, addr, wdata, id);
        d_valid = 1'b1;
        d_insn  = insn;
        d_addr  = addr;
        d_wdata = wdata;
        issued  = issued + 1;
        @(posedge clk);
        #2;
        d_valid = 1'b0;
    endtask

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    // Memory answers after 0 to 3 wait cycles.
    always @(posedge clk) begin
        #2;
        if (rst) begin
            bus_ready = 1'b0;
        end else if (bus_re || bus_we != 4'h0) begin
            if (wait_left == 0) begin
                bus_ready = 1'b1;
                bus_rdata = mem[bus_addr[5:0]];
                for (int i = 0; i < 4; i++) begin
                    if (bus_we[i]) begin
                        mem[bus_addr[5:0]][8*i +: 8] = bus_wdata[8*i +: 8];
                    end
                end
                wait_left = int'($urandom % 4);
            end else begin
                wait_left = wait_left - 1;
                bus_ready = 1'b0;
                bus_rdata = $urandom;
            end
        end else begin
            bus_ready = 1'b0;
            bus_rdata = $urandom;
        end
    end

    // Retire the expected entry halfway through the result cycle.
    always @(negedge clk) begin
        if (!rst && q_valid) begin
            head <= head + 1;
        end
    end

    // Checks run mid-cycle, before the entry of the result cycle retires.
    result_count: assert property (@(negedge clk) disable iff (rst) q_valid |-> head < tail)
        else begin
            $display("q_valid seen with no instruction outstanding");
            stop_on_error();
        end

    result_value: assert property (@(negedge clk) disable iff (rst)
        q_valid && head < tail |-> q_rd_val == cur_val)
        else begin
            $display("ERROR %s result expected %h actual %h", test_name($sampled(cur_id)),
                     $sampled(cur_val), $sampled(q_rd_val));
            stop_on_error();
        end

    result_trap: assert property (@(negedge clk) disable iff (rst)
        q_valid && head < tail |-> q_trap == cur_trap && (!cur_trap || q_cause == cur_cause))
        else begin
            $display("ERROR %s trap/cause expected %b/%0d actual %b/%0d",
                     test_name($sampled(cur_id)), $sampled(cur_trap), $sampled(cur_cause),
                     $sampled(q_trap), $sampled(q_cause));
            stop_on_error();
        end

    bus_lanes: assert property (@(negedge clk) disable iff (rst)
        bus_we != 4'h0 |-> head < tail && bus_we == cur_we)
        else begin
            $display("ERROR %s bus_we expected %b actual %b", test_name($sampled(cur_id)),
                     $sampled(cur_we), $sampled(bus_we));
            stop_on_error();
        end

    bus_read: assert property (@(negedge clk) disable iff (rst)
        bus_re |-> head < tail && cur_re)
        else begin
            $display("bus_re asserted for an instruction that must not read");
            stop_on_error();
        end

    bus_word: assert property (@(negedge clk) disable iff (rst)
        (bus_re || bus_we != 4'h0) |-> bus_addr == cur_addr)
        else begin
            $display("ERROR %s bus_addr expected %h actual %h", test_name($sampled(cur_id)),
                     $sampled(cur_addr), $sampled(bus_addr));
            stop_on_error();
        end

    reset_state: assert property (@(negedge clk) $fell(rst) |-> !q_valid && d_ready)
        else begin
            $display("q_valid high or d_ready low right after reset");
            stop_on_error();
        end

    // Hang limit grows with every issued instruction.
    initial begin
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > 200 * issued + 100) begin
                $display("Watchdog expired, the DUT stopped responding");
                $display("ERRORS FOUND");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        int          r;
        logic [31:0] a;
        logic [4:0]  f5;
        void'($urandom(32'h6ecb));
        rst       = 1'b1;
        d_valid   = 1'b0;
        d_insn    = 32'h0;
        d_addr    = 32'h0;
        d_wdata   = 32'h0;
        bus_ready = 1'b0;
        bus_rdata = 32'h0;
        for (int i = 0; i < 64; i++) begin
            mem[i]    = (32'(i) * 32'h0101_0101) ^ 32'h5a3c_0f96 ^ (32'(i) << 20);
            shadow[i] = mem[i];
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        // Every size, sign and offset.
        for (int sz = 0; sz < 3; sz++) begin
            for (int z = 0; z < 2; z++) begin
                for (int off = 0; off < 4; off++) begin
                    issue(enc_load({1'(z), 2'(sz)}), 32'((sz * 2 + z) * 4 + off), 32'h0, 1);
                end
            end
        end

        for (int sz = 0; sz < 3; sz++) begin
            for (int off = 0; off < 4; off++) begin
                issue(enc_store({1'b0, 2'(sz)}), 32'((16 + sz) * 4 + off), $urandom, 2);
                issue(enc_load(3'b010), 32'((16 + sz) * 4), 32'h0, 2);
            end
        end

        issue(enc_load(3'b001), 32'h0000_0041, 32'h0, 3);
        issue(enc_load(3'b101), 32'h0000_0043, 32'h0, 3);
        issue(enc_load(3'b010), 32'h0000_0046, 32'h0, 3);
        issue(enc_store(3'b001), 32'h0000_0049, 32'h1234_5678, 3);
        issue(enc_store(3'b010), 32'h0000_004e, 32'h1234_5678, 3);
        issue(enc_load(3'b010), 32'h0000_0048, 32'h0, 3);

        for (int i = 0; i < 9; i++) begin
            issue(enc_store(3'b010), 32'((32 + i) * 4),
                  (i % 2 == 0) ? 32'hffff_fff0 : 32'h0000_0007, 4);
            issue(enc_amo(5'(f5_list[i]), 3'b010), 32'((32 + i) * 4),
                  (i % 2 == 0) ? 32'h0000_0005 : 32'h8000_0003, 4);
            issue(enc_load(3'b010), 32'((32 + i) * 4), 32'h0, 4);
        end

        issue(32'h0010_0093, 32'h0000_0010, 32'h0, 5);
        issue(enc_amo(5'b00010, 3'b010), 32'h0000_0010, 32'h0, 5);
        issue(enc_amo(5'b00011, 3'b010), 32'h0000_0010, 32'h1, 5);
        issue(enc_amo(5'b00000, 3'b000), 32'h0000_0010, 32'h1, 5);
        issue(enc_load(3'b011), 32'h0000_0010, 32'h0, 5);
        issue(enc_store(3'b011), 32'h0000_0010, 32'h1, 5);

        // Random mix with random bus delays.
        for (int n = 0; n < 200; n++) begin
            r = int'($urandom % 10);
            a = 32'(($urandom % 64) * 4);
            if (r < 4) begin
                issue(enc_load(3'($urandom % 8)), a | 32'($urandom % 4), 32'h0, 6);
            end else if (r < 7) begin
                issue(enc_store({1'b0, 2'($urandom % 3)}), a | 32'($urandom % 4), $urandom, 6);
            end else if (r < 9) begin
                f5 = 5'(f5_list[$urandom % 9]);
                if ($urandom % 8 == 0) begin
                    a = a | 32'($urandom % 4);
                end
                issue(enc_amo(f5, 3'b010), a, $urandom, 6);
            end else begin
                issue(enc_amo(5'b00010, 3'b010), a, 32'h0, 6);
            end
        end

        // A missing result leaves this loop to the watchdog.
        while (head != tail) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// Testbench clock generator with a 20 ns period.
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Half period per phase.
    always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: source/mem_stage.sv
// Memory stage top level joining the request holder and the access controller.
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter bit has_amo = 1'b1
) (
    input  logic              clk,
    input  logic              rst,

    // Decoded instruction from the previous stage.
    input  logic              d_valid,
    output logic              d_ready,
    input  mem_pkg::word_t    d_insn,
    input  mem_pkg::word_t    d_addr,
    input  mem_pkg::word_t    d_wdata,

    // Data bus.
    output logic              bus_re,
    output mem_pkg::lane_t    bus_we,
    output logic [29:0]       bus_addr,
    output mem_pkg::word_t    bus_wdata,
    input  logic              bus_ready,
    input  mem_pkg::word_t    bus_rdata,

    // One result per instruction.
    output logic              q_valid,
    output mem_pkg::word_t    q_rd_val,
    output logic              q_trap,
    output mem_pkg::cause_t   q_cause
);
    import mem_pkg::*;

    logic         req_held;
    logic         req_done;
    kind_e        req_kind;
    access_size_e req_size;
    logic         req_sign;
    amo_op_e      req_rmw_op;
    word_t        req_addr;
    word_t        req_operand;

    mem_request #(
        .has_amo (has_amo)
    ) u_request (
        .clk     (clk),
        .rst     (rst),
        .d_valid (d_valid),
        .d_ready (d_ready),
        .d_insn  (d_insn),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .done    (req_done),
        .held    (req_held),
        .kind    (req_kind),
        .size    (req_size),
        .sign    (req_sign),
        .rmw_op  (req_rmw_op),
        .addr    (req_addr),
        .operand (req_operand)
    );

    mem_access_ctrl u_access_ctrl (
        .clk       (clk),
        .rst       (rst),
        .held      (req_held),
        .kind      (req_kind),
        .size      (req_size),
        .sign      (req_sign),
        .rmw_op    (req_rmw_op),
        .addr      (req_addr),
        .operand   (req_operand),
        .done      (req_done),
        .bus_re    (bus_re),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ready (bus_ready),
        .bus_rdata (bus_rdata),
        .q_valid   (q_valid),
        .q_rd_val  (q_rd_val),
        .q_trap    (q_trap),
        .q_cause   (q_cause)
    );

endmodule

`default_nettype wire

// File: source/mem_request.sv
// Request holder that decodes one memory instruction and keeps it until it completes.
`timescale 1ns/1ps
`default_nettype none

module mem_request #(
    parameter bit has_amo = 1'b1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  d_valid,
    output logic                  d_ready,
    input  mem_pkg::word_t        d_insn,
    input  mem_pkg::word_t        d_addr,
    input  mem_pkg::word_t        d_wdata,
    input  logic                  done,
    output logic                  held,
    output mem_pkg::kind_e        kind,
    output mem_pkg::access_size_e size,
    output logic                  sign,
    output mem_pkg::amo_op_e      rmw_op,
    output mem_pkg::word_t        addr,
    output mem_pkg::word_t        operand
);
    import mem_pkg::*;

    insn_u   in_word;
    kind_e   dec_kind;
    amo_op_e dec_op;
    logic    accept;

    assign in_word = d_insn;
    assign dec_op  = amo_op_e'(in_word.amo.funct5[4:2]);
    assign d_ready = !held;
    assign accept  = d_valid && d_ready;

    // Anything not matched below traps as illegal.
    always_comb begin
        dec_kind = KIND_ILLEGAL;
        if (in_word.mem.quad == 2'b11) begin
            case (in_word.mem.opcode)
                OP_LOAD: begin
                    if (in_word.mem.size != SIZE_RSVD) begin
                        dec_kind = KIND_LOAD;
                    end
                end
                OP_STORE: begin
                    if (in_word.mem.size != SIZE_RSVD) begin
                        dec_kind = KIND_STORE;
                    end
                end
                OP_AMO: begin
                    // LR and SC fall through as illegal.
                    if (has_amo && in_word.amo.funct3 == FUNCT3_AMO_W) begin
                        if (in_word.amo.funct5[1:0] == 2'b00) begin
                            dec_kind = KIND_RMW;
                        end else if (in_word.amo.funct5 == FUNCT5_SWAP) begin
                            dec_kind = KIND_SWAP;
                        end
                    end
                end
                default: dec_kind = KIND_ILLEGAL;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (accept) begin
            held <= 1'b1;
        end else if (done) begin
            held <= 1'b0;
        end
    end

    // Decoded fields, captured with the instruction.
    always_ff @(posedge clk) begin
        if (accept) begin
            kind    <= dec_kind;
            size    <= in_word.mem.size;
            sign    <= !in_word.mem.zext;
            rmw_op  <= dec_op;
            addr    <= d_addr;
            operand <= d_wdata;
        end
    end

    // A held request keeps its fields until the controller finishes it.
    held_until_done: assert property (@(posedge clk) disable iff (rst)
        held && !done |=> held && $stable({kind, size, sign, rmw_op, addr, operand}))
        else $error("held request changed before done");

    // The controller only finishes what was handed to it.
    done_needs_held: assert property (@(posedge clk) disable iff (rst) done |-> held)
        else $error("done without a held request");

endmodule

`default_nettype wire

// File: source/mem_access_ctrl.sv
// Access controller that sequences bus phases, checks alignment and registers the result.
`timescale 1ns/1ps
`default_nettype none

module mem_access_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  held,
    input  mem_pkg::kind_e        kind,
    input  mem_pkg::access_size_e size,
    input  logic                  sign,
    input  mem_pkg::amo_op_e      rmw_op,
    input  mem_pkg::word_t        addr,
    input  mem_pkg::word_t        operand,
    output logic                  done,
    output logic                  bus_re,
    output mem_pkg::lane_t        bus_we,
    output logic [29:0]           bus_addr,
    output mem_pkg::word_t        bus_wdata,
    input  logic                  bus_ready,
    input  mem_pkg::word_t        bus_rdata,
    output logic                  q_valid,
    output mem_pkg::word_t        q_rd_val,
    output logic                  q_trap,
    output mem_pkg::cause_t       q_cause
);
    import mem_pkg::*;

    localparam logic [2:0] ST_CHECK     = 3'd0;
    localparam logic [2:0] ST_ACCESS    = 3'd1;
    localparam logic [2:0] ST_RMW_READ  = 3'd2;
    localparam logic [2:0] ST_RMW_WRITE = 3'd3;
    localparam logic [2:0] ST_FINISH    = 3'd4;

    logic [2:0] st;
    logic [2:0] st_next;
    logic       phase_re;
    logic       phase_we;
    logic       latch_old;
    logic       is_rmw;
    logic       misalign;
    logic       trap_now;
    cause_t     cause_sel;
    word_t      old_word;
    word_t      alu_val;
    word_t      lane_wdata;
    word_t      lane_rdata;
    word_t      result_val;

    assign is_rmw   = (kind == KIND_RMW) || (kind == KIND_SWAP);
    assign misalign = ((size == SIZE_HALF) && addr[0]) ||
                      ((size == SIZE_WORD) && (addr[1:0] != 2'b00));
    assign trap_now = (kind == KIND_ILLEGAL) || misalign;

    always_comb begin
        if (kind == KIND_ILLEGAL) begin
            cause_sel = CAUSE_ILLEGAL;
        end else if (!misalign) begin
            cause_sel = '0;
        end else if (kind == KIND_LOAD) begin
            cause_sel = CAUSE_LOAD_ALIGN;
        end else begin
            // Atomics report as stores.
            cause_sel = CAUSE_STORE_ALIGN;
        end
    end

    // Phase machine. The first cycle of a request already drives the bus.
    always_comb begin
        st_next   = st;
        phase_re  = 1'b0;
        phase_we  = 1'b0;
        latch_old = 1'b0;
        done      = 1'b0;
        case (st)
            ST_CHECK: begin
                if (held && trap_now) begin
                    done    = 1'b1;
                    st_next = ST_FINISH;
                end else if (held) begin
                    phase_re = (kind != KIND_STORE);
                    phase_we = (kind == KIND_STORE);
                    if (bus_ready && is_rmw) begin
                        latch_old = 1'b1;
                        st_next   = ST_RMW_WRITE;
                    end else if (bus_ready) begin
                        done    = 1'b1;
                        st_next = ST_FINISH;
                    end else begin
                        st_next = is_rmw ? ST_RMW_READ : ST_ACCESS;
                    end
                end
            end
            ST_ACCESS: begin
                phase_re = (kind == KIND_LOAD);
                phase_we = (kind == KIND_STORE);
                if (bus_ready) begin
                    done    = 1'b1;
                    st_next = ST_FINISH;
                end
            end
            ST_RMW_READ: begin
                phase_re = 1'b1;
                if (bus_ready) begin
                    latch_old = 1'b1;
                    st_next   = ST_RMW_WRITE;
                end
            end
            ST_RMW_WRITE: begin
                phase_we = 1'b1;
                if (bus_ready) begin
                    done    = 1'b1;
                    st_next = ST_FINISH;
                end
            end
            default: st_next = ST_CHECK;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st <= ST_CHECK;
        end else begin
            st <= st_next;
        end
    end

    always_ff @(posedge clk) begin
        if (latch_old) begin
            old_word <= bus_rdata;
        end
    end

    mem_amo_alu u_amo_alu (
        .op      (rmw_op),
        .swap    (kind == KIND_SWAP),
        .old_val (old_word),
        .operand (operand),
        .new_val (alu_val)
    );

    assign lane_wdata = (kind == KIND_STORE) ? operand : alu_val;

    mem_lanes u_lanes (
        .phase_re  (phase_re),
        .phase_we  (phase_we),
        .size      (size),
        .sign      (sign),
        .addr      (addr),
        .wdata     (lane_wdata),
        .bus_rdata (bus_rdata),
        .bus_re    (bus_re),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .rdata     (lane_rdata)
    );

    // Atomics return the word as it was before the write.
    always_comb begin
        if (trap_now || kind == KIND_STORE) begin
            result_val = '0;
        end else if (is_rmw) begin
            result_val = old_word;
        end else begin
            result_val = lane_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            q_rd_val <= result_val;
            q_trap   <= trap_now;
            q_cause  <= cause_sel;
        end
    end

    assign q_valid = (st == ST_FINISH);

    bus_req_hold: assert property (@(posedge clk) disable iff (rst)
        (bus_re || bus_we != '0) && !bus_ready
            |=> $stable({bus_re, bus_we, bus_addr, bus_wdata}))
        else $error("bus request changed before bus_ready");

endmodule

`default_nettype wire

// File: source/mem_lanes.sv
// Byte lane logic for store steering and load extraction with sign extension.
`timescale 1ns/1ps
`default_nettype none

module mem_lanes (
    input  logic                  phase_re,
    input  logic                  phase_we,
    input  mem_pkg::access_size_e size,
    input  logic                  sign,
    input  mem_pkg::word_t        addr,
    input  mem_pkg::word_t        wdata,
    input  mem_pkg::word_t        bus_rdata,
    output logic                  bus_re,
    output mem_pkg::lane_t        bus_we,
    output logic [29:0]           bus_addr,
    output mem_pkg::word_t        bus_wdata,
    output mem_pkg::word_t        rdata
);
    import mem_pkg::*;

    logic [7:0]  byte_val;
    logic [15:0] half_val;
    logic        lane_ok;

    assign bus_re   = phase_re;
    assign bus_addr = addr[31:2];

    // Narrow stores repeat their data on every lane.
    always_comb begin
        bus_we    = '0;
        bus_wdata = wdata;
        case (size)
            SIZE_BYTE: begin
                bus_wdata = {4{wdata[7:0]}};
                bus_we    = phase_we ? lane_t'(4'b0001 << addr[1:0]) : 4'b0000;
            end
            SIZE_HALF: begin
                bus_wdata = {2{wdata[15:0]}};
                if (phase_we) begin
                    bus_we = addr[1] ? 4'b1100 : 4'b0011;
                end
            end
            SIZE_WORD: bus_we = {4{phase_we}};
            default:   bus_we = '0;
        endcase
    end

    // Pick the addressed byte and half.
    always_comb begin
        case (addr[1:0])
            2'b00:   byte_val = bus_rdata[7:0];
            2'b01:   byte_val = bus_rdata[15:8];
            2'b10:   byte_val = bus_rdata[23:16];
            default: byte_val = bus_rdata[31:24];
        endcase
        half_val = addr[1] ? bus_rdata[31:16] : bus_rdata[15:0];
    end

    always_comb begin
        case (size)
            SIZE_BYTE: rdata = {{24{sign && byte_val[7]}}, byte_val};
            SIZE_HALF: rdata = {{16{sign && half_val[15]}}, half_val};
            default:   rdata = bus_rdata;
        endcase
    end

    // A write phase reaches at least one lane and never overlaps a read.
    assign lane_ok = !phase_we || (!phase_re && bus_we != '0);

    // Unknown phases before the first reset edge are let through.
    always_comb begin
        lane_shape: assert final (lane_ok !== 1'b0)
            else $error("write phase without lanes or overlapping a read");
    end

endmodule

`default_nettype wire

// File: source/mem_amo_alu.sv
// Atomic ALU that computes the value written back by a read-modify-write access.
`timescale 1ns/1ps
`default_nettype none

module mem_amo_alu (
    input  mem_pkg::amo_op_e op,
    input  logic             swap,
    input  mem_pkg::word_t   old_val,
    input  mem_pkg::word_t   operand,
    output mem_pkg::word_t   new_val
);
    import mem_pkg::*;

    logic        sub_en;
    logic        flip_msb;
    word_t       lhs;
    word_t       rhs;
    logic [32:0] sum;
    logic        old_ge;

    // Min and max subtract. The signed pair also flips both sign bits.
    assign sub_en   = op[2];
    assign flip_msb = (op == AMO_MIN) || (op == AMO_MAX);

    assign lhs = old_val ^ {flip_msb, 31'b0};
    assign rhs = operand ^ {flip_msb, 31'b0} ^ {32{sub_en}};

    // One adder for add and every compare.
    assign sum    = {1'b0, lhs} + {1'b0, rhs} + {32'b0, sub_en};
    assign old_ge = sum[32];

    always_comb begin
        if (swap) begin
            new_val = operand;
        end else begin
            case (op)
                AMO_ADD:            new_val = sum[31:0];
                AMO_XOR:            new_val = old_val ^ operand;
                AMO_OR:             new_val = old_val | operand;
                AMO_AND:            new_val = old_val & operand;
                AMO_MIN, AMO_MINU:  new_val = old_ge ? operand : old_val;
                AMO_MAX, AMO_MAXU:  new_val = old_ge ? old_val : operand;
                default:            new_val = sum[31:0];
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
// Memory stage package with word types, opcodes, trap causes and instruction views.
`default_nettype none

package mem_pkg;

    // Data or address word.
    typedef logic [31:0] word_t;

    // One write enable per byte lane.
    typedef logic [3:0] lane_t;

    // Trap cause code.
    typedef logic [3:0] cause_t;

    // Access width, as encoded in funct3[1:0].
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_RSVD = 2'b11
    } access_size_e;

    // Read-modify-write operation, in funct5[4:2] order.
    typedef enum logic [2:0] {
        AMO_ADD  = 3'b000,
        AMO_XOR  = 3'b001,
        AMO_OR   = 3'b010,
        AMO_AND  = 3'b011,
        AMO_MIN  = 3'b100,
        AMO_MAX  = 3'b101,
        AMO_MINU = 3'b110,
        AMO_MAXU = 3'b111
    } amo_op_e;

    // How a held request gets executed.
    typedef enum logic [2:0] {
        KIND_LOAD,
        KIND_STORE,
        KIND_RMW,
        KIND_SWAP,
        KIND_ILLEGAL
    } kind_e;

    // Major opcodes, instruction bits [6:2].
    localparam logic [4:0] OP_LOAD  = 5'b00000;
    localparam logic [4:0] OP_STORE = 5'b01000;
    localparam logic [4:0] OP_AMO   = 5'b01011;

    // Atomics are word only.
    localparam logic [2:0] FUNCT3_AMO_W = 3'b010;
    localparam logic [4:0] FUNCT5_SWAP  = 5'b00001;

    localparam cause_t CAUSE_ILLEGAL     = 4'd2;
    localparam cause_t CAUSE_LOAD_ALIGN  = 4'd4;
    localparam cause_t CAUSE_STORE_ALIGN = 4'd6;

    // Two decodings of the same instruction word.
    typedef union packed {
        struct packed {
            logic [16:0]  upper;
            logic         zext;
            access_size_e size;
            logic [4:0]   rd;
            logic [4:0]   opcode;
            logic [1:0]   quad;
        } mem;
        struct packed {
            logic [4:0] funct5;
            logic       aq;
            logic       rl;
            logic [9:0] regs;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [4:0] opcode;
            logic [1:0] quad;
        } amo;
    } insn_u;

endpackage

`default_nettype wire
